/* verilog.f */
+incdir+include
hdl/mem_stage_pkg.sv
hdl/load_align.sv
hdl/store_merge.sv
hdl/axi_lite_master.sv
hdl/mem_access_seq.sv
hdl/mem_stage.sv
bench/axi_mem_model.sv
bench/tb_mem_stage.sv

/* Makefile */
TOP = tb_mem_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* bench/tb_mem_stage.sv */
`include "mem_stage_consts.svh"

module tb_mem_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_stage_pkg::*;

  localparam logic [63:0] PRE_MUL = 64'h0001_0203_0405_0607;
  localparam logic [63:0] PRE_ADD = 64'h8000_0000_0000_1000;
  localparam int MIXED_OPS = 80;
  localparam int OP_COUNT = 2 + 4 + 29 + 28 + MIXED_OPS; // ops of each test in turn
  localparam int TIMEOUT_CYCLES = 40 * OP_COUNT;

  logic clk = 1'b0;
  logic reset, in_valid, in_ready, in_update_rd, out_valid, out_update_rd;
  mem_op_e in_op;
  logic [`MS_XLEN-1:0] in_addr, in_store_data, out_result, wdata, rdata;
  logic [`MS_REGNO_W-1:0] in_rd_regno, out_rd_regno;
  logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
  logic [`MS_ADDR_W-1:0] awaddr, araddr;
  logic [`MS_STRB_W-1:0] wstrb;
  logic [1:0] bresp, rresp;

  logic [63:0] ref_mem [512];
  logic [15:0] lfsr = 16'd98;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int issued = 0;
  int pulses = 0;

  mem_stage uut (.*);
  axi_mem_model #(.PRE_MUL(PRE_MUL), .PRE_ADD(PRE_ADD)) mem (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (out_valid)
      pulses <= pulses + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // returns the expected result and updates the bench copy of memory for stores
  function automatic logic [63:0] predict_result(input mem_op_e op, input logic [63:0] addr,
                                                 input logic [63:0] data);
    int nbytes;
    int shift;
    logic [8:0] idx;
    logic [63:0] mask;
    logic [63:0] lane;
    idx = addr[11:3];
    case (op)
      op_lb, op_lbu, op_sb: nbytes = 1;
      op_lh, op_lhu, op_sh: nbytes = 2;
      op_lw, op_lwu, op_sw: nbytes = 4;
      op_ld, op_sd:         nbytes = 8;
      default: return addr; // alu result passes through
    endcase
    shift = (int'(addr[2:0]) / nbytes) * nbytes * 8; // offset aligned down to the size
    mask  = (nbytes == 8) ? '1 : (64'd1 << (nbytes * 8)) - 64'd1;
    if (op inside {op_sb, op_sh, op_sw, op_sd}) begin
      ref_mem[idx] = (ref_mem[idx] & ~(mask << shift)) | ((data & mask) << shift);
      return '0;
    end
    lane = (ref_mem[idx] >> shift) & mask;
    if (op inside {op_lb, op_lh, op_lw} && lane[nbytes * 8 - 1])
      lane = lane | ~mask;
    return lane;
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic run_op(input mem_op_e op, input logic [63:0] addr, input logic [63:0] data,
                        input logic [4:0] regno, input logic upd, output int lat);
    logic [63:0] expected;
    expected = predict_result(op, addr, data);
    while (!in_ready) begin
      @(posedge clk);
      #1;
    end
    in_valid      = 1'b1;
    in_op         = op;
    in_addr       = addr;
    in_store_data = data;
    in_rd_regno   = regno;
    in_update_rd  = upd;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    issued++;
    lat = 0;
    while (!out_valid) begin
      check_value("in_ready while busy", 64'(in_ready), 64'd0);
      @(posedge clk);
      #1;
      lat++;
    end
    check_value($sformatf("%s result", op.name()), out_result, expected);
    check_value($sformatf("%s rd_regno", op.name()), 64'(out_rd_regno), 64'(regno));
    check_value($sformatf("%s update_rd", op.name()), 64'(out_update_rd), 64'(upd));
    @(posedge clk);
    #1;
    check_value("out_valid lasts one cycle", 64'(out_valid), 64'd0);
  endtask

  task automatic reset_and_passthrough();
    int lat;
    check_value("in_ready after reset", 64'(in_ready), 64'd1);
    check_value("out_valid after reset", 64'(out_valid), 64'd0);
    check_value("arvalid after reset", 64'(arvalid), 64'd0);
    check_value("awvalid after reset", 64'(awvalid), 64'd0);
    check_value("wvalid after reset", 64'(wvalid), 64'd0);
    check_value("bready after reset", 64'(bready), 64'd0);
    check_value("rready after reset", 64'(rready), 64'd0);
    run_op(op_none, 64'hdead_beef_0bad_f00d, 64'd0, 5'd7, 1'b1, lat);
    check_value("non-memory latency", 64'(lat), 64'd0); // out_valid in the cycle after accept
    run_op(op_none, 64'h0123_4567_89ab_cdef, 64'hffff, 5'd31, 1'b0, lat);
    check_value("non-memory latency", 64'(lat), 64'd0);
  endtask

  task automatic dword_store_load();
    int lat;
    run_op(op_sd, 64'h40, 64'h5a5a_0f0f_1234_8765, 5'd3, 1'b0, lat);
    run_op(op_ld, 64'h40, 64'd0, 5'd4, 1'b1, lat);
    run_op(op_ld, 64'h803, 64'd0, 5'd5, 1'b1, lat); // untouched and misaligned
    run_op(op_ld, 64'hff8, 64'd0, 5'd6, 1'b1, lat);
  endtask

  task automatic subword_loads();
    int lat;
    run_op(op_sd, 64'h100, 64'hf1e2_d3c4_b5a6_9788, 5'd1, 1'b0, lat); // every lane msb set
    for (int i = 0; i < 8; i++) begin
      run_op(op_lb, 64'h100 + 64'(i), 64'd0, 5'd2, 1'b1, lat);
      run_op(op_lbu, 64'h100 + 64'(i), 64'd0, 5'd2, 1'b1, lat);
    end
    for (int i = 0; i < 8; i += 2) begin
      run_op(op_lh, 64'h100 + 64'(i), 64'd0, 5'd8, 1'b1, lat);
      run_op(op_lhu, 64'h100 + 64'(i), 64'd0, 5'd8, 1'b1, lat);
    end
    for (int i = 0; i < 8; i += 4) begin
      run_op(op_lw, 64'h100 + 64'(i), 64'd0, 5'd9, 1'b1, lat);
      run_op(op_lwu, 64'h100 + 64'(i), 64'd0, 5'd9, 1'b1, lat);
    end
  endtask

  task automatic store_then_load(input mem_op_e op, input int offs);
    int lat;
    run_op(op, 64'h200 + 64'(offs), 64'h1111_2222_3333_4480 + 64'(offs), 5'd10, 1'b0, lat);
    run_op(op_ld, 64'h200, 64'd0, 5'd11, 1'b1, lat);
  endtask

  task automatic partial_stores();
    for (int i = 0; i < 8; i++)
      store_then_load(op_sb, i);
    for (int i = 0; i < 8; i += 2)
      store_then_load(op_sh, i);
    for (int i = 0; i < 8; i += 4)
      store_then_load(op_sw, i);
  endtask

  task automatic mixed_stream();
    mem_op_e op;
    logic [63:0] addr;
    int lat;
    for (int n = 0; n < MIXED_OPS; n++) begin
      op   = mem_op_e'(4'(rand_bits(4) % 12));
      addr = (rand_bits(52) << 12) | (64'h300 + rand_bits(6)); // small window so addresses repeat
      repeat (int'(rand_bits(2))) begin
        @(posedge clk);
        #1;
      end
      run_op(op, addr, rand_bits(64), 5'(rand_bits(5)), 1'(rand_bits(1)), lat);
    end
  endtask

  initial begin
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_op         = op_none;
    in_addr       = '0;
    in_store_data = '0;
    in_rd_regno   = '0;
    in_update_rd  = 1'b0;
    for (int i = 0; i < 512; i++)
      ref_mem[i] = 64'(i) * PRE_MUL + PRE_ADD;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_and_passthrough();
    dword_store_load();
    subword_loads();
    partial_stores();
    mixed_stream();
    check_value("out_valid pulses per operation", 64'(pulses), 64'(issued));
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* bench/axi_mem_model.sv */
`include "mem_stage_consts.svh"

module axi_mem_model #(
  parameter logic [63:0] PRE_MUL = 64'd1,
  parameter logic [63:0] PRE_ADD = 64'd0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`MS_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [`MS_XLEN-1:0]   wdata,
  input  logic [`MS_STRB_W-1:0] wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [`MS_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [`MS_XLEN-1:0]   rdata,
  output logic [1:0]            rresp
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`MS_XLEN-1:0]   mem [512];
  logic [15:0]           lfsr = 16'd98;
  logic [1:0]            ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic                  r_pending, aw_got, w_got;
  logic [8:0]            rd_idx, wr_idx; // 512 doublewords, addr bits 11:3
  logic [`MS_XLEN-1:0]   w_data_r;
  logic [`MS_STRB_W-1:0] w_strb_r;

  assign bresp = `MS_RESP_OKAY;
  assign rresp = `MS_RESP_OKAY;

  initial begin
    for (int i = 0; i < 512; i++)
      mem[i] = 64'(i) * PRE_MUL + PRE_ADD;
  end

  // galois lfsr, one step per bit drawn
  function automatic logic [1:0] wait_cycles();
    logic [1:0] w;
    for (int i = 0; i < 2; i++) begin
      w    = {w[0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return w;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      {arready, rvalid, r_pending} <= '0;
      {awready, wready, bvalid, aw_got, w_got} <= '0;
      {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
    end else begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      if (arvalid && arready) begin
        rd_idx    <= araddr[11:3];
        r_pending <= 1'b1;
      end else if (arvalid && !r_pending && !rvalid) begin
        arready <= (ar_wait == 2'd0);
        ar_wait <= (ar_wait == 2'd0) ? wait_cycles() : ar_wait - 2'd1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (r_pending) begin
        if (r_wait == 2'd0) begin
          rdata     <= mem[rd_idx];
          rvalid    <= 1'b1;
          r_pending <= 1'b0;
          r_wait    <= wait_cycles();
        end else
          r_wait <= r_wait - 2'd1;
      end
      // aw and w are taken independently
      if (awvalid && awready) begin
        wr_idx <= awaddr[11:3];
        aw_got <= 1'b1;
      end else if (awvalid && !aw_got) begin
        awready <= (aw_wait == 2'd0);
        aw_wait <= (aw_wait == 2'd0) ? wait_cycles() : aw_wait - 2'd1;
      end
      if (wvalid && wready) begin
        w_data_r <= wdata;
        w_strb_r <= wstrb;
        w_got    <= 1'b1;
      end else if (wvalid && !w_got) begin
        wready <= (w_wait == 2'd0);
        w_wait <= (w_wait == 2'd0) ? wait_cycles() : w_wait - 2'd1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (aw_got && w_got) begin
        if (b_wait == 2'd0) begin
          for (int b = 0; b < `MS_STRB_W; b++)
            if (w_strb_r[b])
              mem[wr_idx][b*8 +: 8] <= w_data_r[b*8 +: 8];
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
          b_wait <= wait_cycles();
        end else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

/* hdl/mem_stage.sv */
`include "mem_stage_consts.svh"

module mem_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  mem_stage_pkg::mem_op_e   in_op,
  input  logic [`MS_XLEN-1:0]      in_addr,
  input  logic [`MS_XLEN-1:0]      in_store_data,
  input  logic [`MS_REGNO_W-1:0]   in_rd_regno,
  input  logic                     in_update_rd,
  output logic                     in_ready,
  output logic                     out_valid,
  output logic [`MS_XLEN-1:0]      out_result,
  output logic [`MS_REGNO_W-1:0]   out_rd_regno,
  output logic                     out_update_rd,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [`MS_ADDR_W-1:0]    awaddr,
  output logic                     wvalid,
  input  logic                     wready,
  output logic [`MS_XLEN-1:0]      wdata,
  output logic [`MS_STRB_W-1:0]    wstrb,
  input  logic                     bvalid,
  output logic                     bready,
  input  logic [1:0]               bresp,
  output logic                     arvalid,
  input  logic                     arready,
  output logic [`MS_ADDR_W-1:0]    araddr,
  input  logic                     rvalid,
  output logic                     rready,
  input  logic [`MS_XLEN-1:0]      rdata,
  input  logic [1:0]               rresp
);
  import mem_stage_pkg::*;

  logic                  rd_req, wr_req;
  logic                  rd_done, wr_done;
  logic [`MS_ADDR_W-1:0] req_addr;
  logic [`MS_XLEN-1:0]   wr_data;
  logic [`MS_XLEN-1:0]   rd_data;
  mem_op_e               hold_op;
  logic [`MS_OFFS_W-1:0] hold_offs;
  logic [`MS_XLEN-1:0]   hold_store_data;
  logic [`MS_XLEN-1:0]   load_value;
  logic [`MS_XLEN-1:0]   merged_data;

  mem_access_seq seq (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_op(in_op), .in_addr(in_addr),
    .in_store_data(in_store_data), .in_rd_regno(in_rd_regno),
    .in_update_rd(in_update_rd), .in_ready(in_ready),
    .out_valid(out_valid), .out_result(out_result),
    .out_rd_regno(out_rd_regno), .out_update_rd(out_update_rd),
    .rd_req(rd_req), .wr_req(wr_req), .req_addr(req_addr), .wr_data(wr_data),
    .rd_done(rd_done), .wr_done(wr_done), .rd_data(rd_data),
    .hold_op(hold_op), .hold_offs(hold_offs), .hold_store_data(hold_store_data),
    .load_value(load_value), .merged_data(merged_data)
  );

  axi_lite_master axi (
    .clk(clk), .reset(reset),
    .rd_req(rd_req), .wr_req(wr_req), .req_addr(req_addr), .wr_data(wr_data),
    .rd_done(rd_done), .wr_done(wr_done), .rd_data(rd_data),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  // both read the doubleword the master holds from the last read
  load_align align (
    .op(hold_op), .offs(hold_offs), .dword(rd_data), .value(load_value)
  );

  store_merge merge (
    .op(hold_op), .offs(hold_offs), .old_dword(rd_data),
    .store_data(hold_store_data), .dword(merged_data)
  );

endmodule

/* hdl/mem_access_seq.sv */
`include "mem_stage_consts.svh"

module mem_access_seq (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  mem_stage_pkg::mem_op_e   in_op,
  input  logic [`MS_XLEN-1:0]      in_addr,
  input  logic [`MS_XLEN-1:0]      in_store_data,
  input  logic [`MS_REGNO_W-1:0]   in_rd_regno,
  input  logic                     in_update_rd,
  output logic                     in_ready,
  output logic                     out_valid,
  output logic [`MS_XLEN-1:0]      out_result,
  output logic [`MS_REGNO_W-1:0]   out_rd_regno,
  output logic                     out_update_rd,
  output logic                     rd_req,
  output logic                     wr_req,
  output logic [`MS_ADDR_W-1:0]    req_addr,
  output logic [`MS_XLEN-1:0]      wr_data,
  input  logic                     rd_done,
  input  logic                     wr_done,
  input  logic [`MS_XLEN-1:0]      rd_data,
  output mem_stage_pkg::mem_op_e   hold_op,
  output logic [`MS_OFFS_W-1:0]    hold_offs,
  output logic [`MS_XLEN-1:0]      hold_store_data,
  input  logic [`MS_XLEN-1:0]      load_value,
  input  logic [`MS_XLEN-1:0]      merged_data
);
  import mem_stage_pkg::*;

  typedef enum logic [1:0] {st_idle, st_read, st_write, st_finish} state_e;

  state_e                state;
  logic [`MS_ADDR_W-1:0] hold_addr;
  logic                  accept;
  logic                  in_needs_read;
  logic                  partial_store;

  assign in_ready  = (state == st_idle);
  assign accept    = in_valid && in_ready;
  assign out_valid = (state == st_finish); // one cycle, then back to idle

  // sb/sh/sw go through read-modify-write
  assign in_needs_read = op_is_load(in_op) ||
                         (op_is_store(in_op) && op_size(in_op) != size_dword);
  assign partial_store = op_is_store(hold_op) && op_size(hold_op) != size_dword;

  assign req_addr  = {hold_addr[`MS_ADDR_W-1:`MS_OFFS_W], {`MS_OFFS_W{1'b0}}};
  assign hold_offs = hold_addr[`MS_OFFS_W-1:0];
  assign wr_data   = partial_store ? merged_data : hold_store_data;

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_op         <= in_op;
      hold_addr       <= in_addr[`MS_ADDR_W-1:0];
      hold_store_data <= in_store_data;
      out_rd_regno    <= in_rd_regno;
      out_update_rd   <= in_update_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      rd_req <= 1'b0;
      wr_req <= 1'b0;
    end else begin
      rd_req <= 1'b0;
      wr_req <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            if (in_needs_read) begin
              state  <= st_read;
              rd_req <= 1'b1;
            end else if (op_is_store(in_op)) begin // sd
              state  <= st_write;
              wr_req <= 1'b1;
            end else begin
              state <= st_finish;
            end
          end
        end
        st_read: begin
          if (rd_done) begin
            if (partial_store) begin
              state  <= st_write;
              wr_req <= 1'b1; // merged data is ready now
            end else begin
              state <= st_finish;
            end
          end
        end
        st_write: begin
          if (wr_done)
            state <= st_finish;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      out_result <= in_addr; // alu result kept for non-memory ops
    else if (state == st_read && rd_done && !partial_store)
      out_result <= load_value;
    else if (state == st_write && wr_done)
      out_result <= '0;
  end

endmodule

/* hdl/axi_lite_master.sv */
`include "mem_stage_consts.svh"

module axi_lite_master (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rd_req,
  input  logic                     wr_req,
  input  logic [`MS_ADDR_W-1:0]    req_addr,
  input  logic [`MS_XLEN-1:0]      wr_data,
  output logic                     rd_done,
  output logic                     wr_done,
  output logic [`MS_XLEN-1:0]      rd_data,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [`MS_ADDR_W-1:0]    awaddr,
  output logic                     wvalid,
  input  logic                     wready,
  output logic [`MS_XLEN-1:0]      wdata,
  output logic [`MS_STRB_W-1:0]    wstrb,
  input  logic                     bvalid,
  output logic                     bready,
  input  logic [1:0]               bresp,
  output logic                     arvalid,
  input  logic                     arready,
  output logic [`MS_ADDR_W-1:0]    araddr,
  input  logic                     rvalid,
  output logic                     rready,
  input  logic [`MS_XLEN-1:0]      rdata,
  input  logic [1:0]               rresp
);

  typedef enum logic [1:0] {m_idle, m_read, m_write} state_e;

  state_e                state;
  logic [`MS_ADDR_W-1:0] addr_r; // one request at a time, so AR and AW share it

  assign araddr = addr_r;
  assign awaddr = addr_r;
  assign wstrb  = '1; // partial stores are merged upstream
  assign rready = (state == m_read);
  assign bready = (state == m_write);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= m_idle;
      arvalid <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      rd_done <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      wr_done <= 1'b0;
      case (state)
        m_idle: begin
          if (rd_req) begin
            arvalid <= 1'b1;
            state   <= m_read;
          end else if (wr_req) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= m_write;
          end
        end
        m_read: begin
          if (arvalid && arready)
            arvalid <= 1'b0;
          if (rvalid && rready) begin
            rd_done <= 1'b1;
            state   <= m_idle;
          end
        end
        m_write: begin
          // aw and w may finish in either order
          if (awvalid && awready)
            awvalid <= 1'b0;
          if (wvalid && wready)
            wvalid <= 1'b0;
          if (bvalid && bready) begin
            wr_done <= 1'b1;
            state   <= m_idle;
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == m_idle && (rd_req || wr_req))
      addr_r <= req_addr;
    if (state == m_idle && wr_req)
      wdata <= wr_data;
    if (rvalid && rready)
      rd_data <= rdata; // stays until the next read
  end

endmodule

/* hdl/store_merge.sv */
`include "mem_stage_consts.svh"

module store_merge (
  input  mem_stage_pkg::mem_op_e   op,
  input  logic [`MS_OFFS_W-1:0]    offs,
  input  logic [`MS_XLEN-1:0]      old_dword,
  input  logic [`MS_XLEN-1:0]      store_data,
  output logic [`MS_XLEN-1:0]      dword
);
  import mem_stage_pkg::*;

  access_size_e size;

  assign size = op_size(op);

  // the lane base comes from the offset rounded down to the access size
  always_comb begin
    dword = old_dword;
    case (size)
      size_byte: dword[offs*8 +: 8]        = store_data[7:0];
      size_half: dword[offs[2:1]*16 +: 16] = store_data[15:0];
      size_word: dword[offs[2]*32 +: 32]   = store_data[31:0];
      default:   dword = old_dword; // sd bypasses the merge
    endcase
  end

endmodule

/* hdl/load_align.sv */
`include "mem_stage_consts.svh"

module load_align (
  input  mem_stage_pkg::mem_op_e   op,
  input  logic [`MS_OFFS_W-1:0]    offs,
  input  logic [`MS_XLEN-1:0]      dword,
  output logic [`MS_XLEN-1:0]      value
);
  import mem_stage_pkg::*;

  access_size_e          size;
  logic                  sext;
  logic [`MS_OFFS_W-1:0] lane_offs;
  logic [`MS_XLEN-1:0]   lane;

  assign size = op_size(op);
  assign sext = op_is_signed(op);

  // low offset bits below the access size are dropped
  always_comb begin
    case (size)
      size_byte: lane_offs = offs;
      size_half: lane_offs = offs & {{(`MS_OFFS_W-1){1'b1}}, 1'b0};
      size_word: lane_offs = offs & {1'b1, {(`MS_OFFS_W-1){1'b0}}};
      default:   lane_offs = '0;
    endcase
  end

  assign lane = dword >> {lane_offs, 3'b000};

  always_comb begin
    case (size)
      size_byte: value = {{(`MS_XLEN-8){sext & lane[7]}}, lane[7:0]};
      size_half: value = {{(`MS_XLEN-16){sext & lane[15]}}, lane[15:0]};
      size_word: value = {{(`MS_XLEN-32){sext & lane[31]}}, lane[31:0]};
      default:   value = lane;
    endcase
  end

endmodule

/* hdl/mem_stage_pkg.sv */
package mem_stage_pkg;

  typedef enum logic [3:0] {
    op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
    op_sb, op_sh, op_sw, op_sd
  } mem_op_e;

  typedef enum logic [1:0] {size_byte, size_half, size_word, size_dword} access_size_e;

  function automatic access_size_e op_size(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return size_byte;
      op_lh, op_lhu, op_sh: return size_half;
      op_lw, op_lwu, op_sw: return size_word;
      default: return size_dword;
    endcase
  endfunction

  function automatic logic op_is_signed(mem_op_e op);
    return op inside {op_lb, op_lh, op_lw, op_ld};
  endfunction

  function automatic logic op_is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

endpackage

/* include/mem_stage_consts.svh */
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// data path
`define MS_XLEN 64
`define MS_REGNO_W 5

// axi4-lite side
`define MS_ADDR_W 32
`define MS_STRB_W (`MS_XLEN / 8)

// byte offset inside one doubleword
`define MS_OFFS_W 3

`define MS_RESP_OKAY 2'b00

`endif
